// ==== hdl/backend_pkg.sv ====
package backend_pkg;

    localparam int ROB_DEPTH = 8;     // rob entries, also the initial credit count
    localparam int ROB_TAG_W = 3;
    localparam int XLEN      = 32;
    localparam int NUM_UNITS = 2;     // cdb requesters, alu is 0 and mul is 1

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [4:0]           arch_reg_t;
    typedef logic [15:0]          seq_t;
    typedef logic [3:0]           credit_t;  // 0 to ROB_DEPTH

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_mul
    } fu_op_e;

    typedef struct packed {
        fu_op_e    op;
        word_t     src_a;
        word_t     src_b;
        arch_reg_t rd;
        seq_t      seq;
    } dispatch_req_t;

    typedef struct packed {
        rob_tag_t tag;
        fu_op_e   op;
        word_t    src_a;
        word_t    src_b;
    } fu_issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    result;
    } cdb_t;

    typedef struct packed {
        arch_reg_t rd;
        word_t     result;
        seq_t      seq;
    } retire_t;

    // one reorder buffer slot
    typedef struct packed {
        logic      busy;
        logic      done;
        arch_reg_t rd;
        seq_t      seq;
        word_t     result;
    } rob_entry_t;

endpackage

// ==== hdl/dispatch_stage.sv ====
module dispatch_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      disp_valid,
    input  backend_pkg::dispatch_req_t disp_req,
    output logic                      disp_ready,
    input  logic                      alu_ready,
    input  logic                      mul_ready,
    input  logic                      credit_return,
    input  backend_pkg::rob_tag_t     alloc_tag,
    output logic                      alloc_valid,
    output backend_pkg::dispatch_req_t alloc_entry,
    output logic                      alu_issue_valid,
    output backend_pkg::fu_issue_t    alu_issue,
    output logic                      mul_issue_valid,
    output backend_pkg::fu_issue_t    mul_issue
);
    import backend_pkg::*;

    credit_t credits;
    logic    is_mul;
    logic    unit_ready;
    logic    accept;

    assign is_mul     = (disp_req.op == op_mul);
    assign unit_ready = is_mul ? mul_ready : alu_ready;
    assign disp_ready = (credits != '0) && unit_ready;
    assign accept     = disp_valid && disp_ready;

    assign alloc_valid = accept;
    assign alloc_entry = disp_req;

    // both units see the same payload, only valid is steered
    assign alu_issue = '{tag: alloc_tag, op: disp_req.op, src_a: disp_req.src_a,
                         src_b: disp_req.src_b};
    assign mul_issue = alu_issue;
    assign alu_issue_valid = accept && !is_mul;
    assign mul_issue_valid = accept && is_mul;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(ROB_DEPTH);
        end else begin
            credits <= credits + credit_t'(credit_return) - credit_t'(accept);
        end
    end

    // rob must never hand back more credits than it has entries
    assert property (@(posedge clk) disable iff (rst) credits <= ROB_DEPTH)
        else $error("credit count above rob depth");

endmodule

// ==== hdl/alu_unit.sv ====
module alu_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  backend_pkg::fu_issue_t issue,
    output logic                   ready,
    output logic                   req,
    output backend_pkg::cdb_t      req_data,
    input  logic                   grant
);
    import backend_pkg::*;

    logic     hold_valid;
    rob_tag_t hold_tag;
    word_t    hold_result;
    word_t    alu_result;

    always_comb begin
        case (issue.op)
            op_sub:  alu_result = issue.src_a - issue.src_b;
            op_xor:  alu_result = issue.src_a ^ issue.src_b;
            default: alu_result = issue.src_a + issue.src_b;
        endcase
    end

    assign ready = !hold_valid || grant;  // slot frees up on grant
    assign req   = hold_valid;
    assign req_data = '{valid: hold_valid, tag: hold_tag, result: hold_result};

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (issue_valid && ready) begin
            hold_valid <= 1'b1;
        end else if (grant) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && ready) begin
            hold_tag    <= issue.tag;
            hold_result <= alu_result;
        end
    end

    // dispatch steers multiplies elsewhere
    assert property (@(posedge clk) disable iff (rst) issue_valid |-> issue.op != op_mul)
        else $error("alu issued a multiply");

endmodule

// ==== hdl/mul_unit.sv ====
module mul_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  backend_pkg::fu_issue_t issue,
    output logic                   ready,
    output logic                   req,
    output backend_pkg::cdb_t      req_data,
    input  logic                   grant
);
    import backend_pkg::*;

    logic [2:0]  stage_valid;
    rob_tag_t    s1_tag, s2_tag, s3_tag;
    word_t       s1_a, s1_b;
    word_t       s2_p0;       // a_lo * b
    logic [15:0] s2_p1;       // a_hi * b_lo, only low half reaches bits 31:16
    word_t       s3_prod;
    logic        advance;

    // whole pipe freezes while stage 3 waits for the bus
    assign advance = !stage_valid[2] || grant;
    assign ready   = advance;
    assign req     = stage_valid[2];
    assign req_data = '{valid: stage_valid[2], tag: s3_tag, result: s3_prod};

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[1:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_tag  <= issue.tag;
            s1_a    <= issue.src_a;
            s1_b    <= issue.src_b;
            s2_tag  <= s1_tag;
            s2_p0   <= word_t'(s1_a[15:0] * s1_b);
            s2_p1   <= 16'(s1_a[31:16] * s1_b[15:0]);
            s3_tag  <= s2_tag;
            s3_prod <= s2_p0 + {s2_p1, 16'h0000};  // low 32 bits of the product
        end
    end

endmodule

// ==== hdl/cdb_arbiter.sv ====
module cdb_arbiter (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [backend_pkg::NUM_UNITS-1:0]          req,
    input  backend_pkg::cdb_t [backend_pkg::NUM_UNITS-1:0] req_data,
    output logic [backend_pkg::NUM_UNITS-1:0]          grant,
    output backend_pkg::cdb_t                          cdb
);
    import backend_pkg::*;

    typedef logic [$clog2(NUM_UNITS)-1:0] unit_idx_t;

    unit_idx_t last_idx;
    unit_idx_t gnt_idx;

    // search starts one past the last winner
    always_comb begin
        grant   = '0;
        gnt_idx = last_idx;
        for (int i = 1; i <= NUM_UNITS; i++) begin
            if (grant == '0 && req[(int'(last_idx) + i) % NUM_UNITS]) begin
                gnt_idx        = unit_idx_t'((int'(last_idx) + i) % NUM_UNITS);
                grant[gnt_idx] = 1'b1;
            end
        end
    end

    always_comb begin
        cdb       = req_data[gnt_idx];
        cdb.valid = |grant;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_idx <= unit_idx_t'(NUM_UNITS - 1);  // unit 0 wins first
        end else if (|grant) begin
            last_idx <= gnt_idx;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("more than one cdb grant");

endmodule

// ==== hdl/reorder_buffer.sv ====
module reorder_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc_valid,
    input  backend_pkg::dispatch_req_t alloc_entry,
    output backend_pkg::rob_tag_t      alloc_tag,
    input  backend_pkg::cdb_t          cdb,
    output logic                       retire_valid,
    output backend_pkg::retire_t       retire,
    output logic                       credit_return
);
    import backend_pkg::*;

    rob_entry_t entries [ROB_DEPTH];

    logic [ROB_TAG_W:0] head_ptr;   // msb is the wrap bit
    logic [ROB_TAG_W:0] tail_ptr;
    rob_tag_t           head_idx;
    rob_tag_t           tail_idx;
    rob_entry_t         head_entry;

    assign head_idx   = head_ptr[ROB_TAG_W-1:0];
    assign tail_idx   = tail_ptr[ROB_TAG_W-1:0];
    assign head_entry = entries[head_idx];
    assign alloc_tag  = tail_idx;

    // retire straight out of the head slot
    assign retire_valid  = head_entry.busy && head_entry.done;
    assign credit_return = retire_valid;
    assign retire = '{rd: head_entry.rd, result: head_entry.result, seq: head_entry.seq};

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (alloc_valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (retire_valid) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    // entry status and payload
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            if (retire_valid) begin
                entries[head_idx].busy <= 1'b0;
                entries[head_idx].done <= 1'b0;
            end
            if (alloc_valid) begin
                entries[tail_idx].busy <= 1'b1;
                entries[tail_idx].done <= 1'b0;
                entries[tail_idx].rd   <= alloc_entry.rd;
                entries[tail_idx].seq  <= alloc_entry.seq;
            end
            if (cdb.valid) begin
                entries[cdb.tag].done <= 1'b1;
                // x0 always reads back zero
                if (entries[cdb.tag].rd == '0) begin
                    entries[cdb.tag].result <= '0;
                end else begin
                    entries[cdb.tag].result <= cdb.result;
                end
            end
        end
    end

    // credits in dispatch should keep the tail off live entries
    assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> !entries[tail_idx].busy)
        else $error("allocation into a busy rob entry");

    // wrap bits tell a full buffer from an empty one
    assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> (tail_ptr ^ head_ptr) != {1'b1, {ROB_TAG_W{1'b0}}})
        else $error("allocation into a full rob");

    assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> entries[cdb.tag].busy)
        else $error("cdb write to a free rob entry");

    assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> !entries[cdb.tag].done)
        else $error("second cdb write to a completed rob entry");

endmodule

// ==== hdl/backend_top.sv ====
module backend_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       disp_valid,
    input  backend_pkg::dispatch_req_t disp_req,
    output logic                       disp_ready,
    output logic                       retire_valid,
    output backend_pkg::retire_t       retire
);
    import backend_pkg::*;

    logic                          alu_ready, mul_ready;
    logic                          credit_return;
    rob_tag_t                      alloc_tag;
    logic                          alloc_valid;
    dispatch_req_t                 alloc_entry;
    logic                          alu_issue_valid, mul_issue_valid;
    fu_issue_t                     alu_issue, mul_issue;
    logic [NUM_UNITS-1:0]          req;    // bit 0 alu, bit 1 mul
    cdb_t [NUM_UNITS-1:0]          req_data;
    logic [NUM_UNITS-1:0]          grant;
    cdb_t                          cdb;

    dispatch_stage dispatch_i (
        .clk, .rst, .disp_valid, .disp_req, .disp_ready, .alu_ready, .mul_ready,
        .credit_return, .alloc_tag, .alloc_valid, .alloc_entry,
        .alu_issue_valid, .alu_issue, .mul_issue_valid, .mul_issue
    );

    alu_unit alu_i (
        .clk, .rst, .issue_valid(alu_issue_valid), .issue(alu_issue), .ready(alu_ready),
        .req(req[0]), .req_data(req_data[0]), .grant(grant[0])
    );

    mul_unit mul_i (
        .clk, .rst, .issue_valid(mul_issue_valid), .issue(mul_issue), .ready(mul_ready),
        .req(req[1]), .req_data(req_data[1]), .grant(grant[1])
    );

    cdb_arbiter arbiter_i (.clk, .rst, .req, .req_data, .grant, .cdb);

    reorder_buffer rob_i (
        .clk, .rst, .alloc_valid, .alloc_entry, .alloc_tag, .cdb,
        .retire_valid, .retire, .credit_return
    );

endmodule

// ==== sim/tb_backend.sv ====
module tb_backend;
    import backend_pkg::*;

    logic          clk;
    logic          rst;
    logic          disp_valid;
    dispatch_req_t disp_req;
    logic          disp_ready;
    logic          retire_valid;
    retire_t       retire;

    dispatch_req_t req_q[$];      // one per file line with seq as index
    word_t         exp_q[$];
    logic          loaded;
    int            num_lines;
    int            accepted;
    int            retired;
    int            max_in_flight;
    logic [31:0]   lcg_state;

    backend_top dut_i (
        .clk, .rst, .disp_valid, .disp_req, .disp_ready, .retire_valid, .retire
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_vals(input logic [63:0] actual, input logic [63:0] expected,
                                input string msg);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got %0h expected %0h",
                     $time, msg, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    // reads hex op a b rd result lines and skips # comments
    task automatic read_input();
        int            fd;
        string         line;
        logic [31:0]   f_op, f_a, f_b, f_rd, f_res;
        dispatch_req_t r;
        fd = $fopen("sim/dispatch_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/dispatch_input.txt for reading");
            $display("*** FAILED ***");
            $fatal(1, "missing input file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_rd, f_res) == 5) begin
                    r.op    = fu_op_e'(f_op[1:0]);
                    r.src_a = f_a;
                    r.src_b = f_b;
                    r.rd    = arch_reg_t'(f_rd);
                    r.seq   = seq_t'(req_q.size());
                    req_q.push_back(r);
                    exp_q.push_back(f_res);
                end
            end
        end
        $fclose(fd);
    endtask

    // starts on a falling edge, returns on the falling edge after acceptance
    task automatic send_instr(input dispatch_req_t r);
        disp_valid = 1'b1;
        disp_req   = r;
        #1;
        while (!disp_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    task automatic check_retire();
        compare_vals(retired < num_lines, 1, "retirement beyond the last instruction");
        compare_vals(retire.seq, retired, "retire seq out of program order");
        compare_vals(retire.rd, req_q[retired].rd, "retire rd");
        compare_vals(retire.result, exp_q[retired], "retire result");
        retired++;
    endtask

    // samples mid low phase once outputs settle
    always @(negedge clk) begin
        #1;
        if (!rst) begin
            compare_vals(accepted - retired <= ROB_DEPTH, 1, "more in flight than rob entries");
            if (accepted - retired == ROB_DEPTH) begin
                compare_vals(disp_ready, 0, "disp_ready high with no credits left");
            end
            if (accepted - retired > max_in_flight) begin
                max_in_flight = accepted - retired;
            end
            if (disp_valid && disp_ready) begin
                accepted++;
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (num_lines * 40 + 100) @(posedge clk);
        $display("timeout: retirement did not finish, %0d of %0d instructions retired",
                 retired, num_lines);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int gap;
        clk           = 1'b0;
        rst           = 1'b1;
        disp_valid    = 1'b0;
        disp_req      = '0;
        loaded        = 1'b0;
        accepted      = 0;
        retired       = 0;
        max_in_flight = 0;
        lcg_state     = 32'h99ff_2724;

        read_input();
        num_lines = req_q.size();
        compare_vals(num_lines > 0, 1, "input file holds no instructions");
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        compare_vals(retire_valid, 0, "retire_valid high after reset");
        compare_vals(disp_ready, 1, "disp_ready low after reset");
        @(negedge clk);

        for (int i = 0; i < num_lines; i++) begin
            lcg_state = lcg_next(lcg_state);
            gap = int'(lcg_state[17:16]);   // 0 to 3 idle cycles
            repeat (gap) @(negedge clk);
            send_instr(req_q[i]);
        end

        wait (retired == num_lines);
        repeat (5) @(negedge clk);   // catch any stray extra retirement
        $display("%0d instructions retired, peak in flight %0d", retired, max_in_flight);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== sim/dispatch_input.txt ====
# op (0 add, 1 sub, 2 xor, 3 mul)  src_a  src_b  rd  expected result, all hex
# rd 00 always retires with result zero
0 00000005 00000007 01 0000000c
1 00000010 00000003 02 0000000d
2 f0f0f0f0 0ff00ff0 03 ff00ff00
3 00000006 00000007 04 0000002a
0 ffffffff 00000001 05 00000000
1 00000000 00000001 06 ffffffff
3 00010000 00010000 07 00000000
0 00000003 00000004 00 00000000
3 12345678 00000010 08 23456780
3 ffffffff ffffffff 09 00000001
3 0000ffff 0000ffff 0a fffe0001
3 00000100 00000100 0b 00010000
3 deadbeef 00000002 0c bd5b7dde
3 00000003 00000005 00 00000000
3 80000000 00000003 0d 80000000
3 00001234 00010000 0e 12340000
0 7fffffff 00000001 0f 80000000
2 aaaaaaaa 55555555 10 ffffffff
1 00000005 0000000a 11 fffffffb
3 0000000b 0000000d 12 0000008f
0 00000100 00000200 13 00000300
2 12345678 12345678 14 00000000
1 00000000 00000000 00 00000000
0 00001000 00000001 1f 00001001

// ==== filelist.f ====
hdl/backend_pkg.sv
hdl/dispatch_stage.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/backend_top.sv
sim/tb_backend.sv
